// ==== design/dotMacPkg.sv ====
`default_nettype none

package dotMacPkg;

    // meaningful widths
    typedef logic signed [15:0] operandT;  // one booth operand
    typedef logic signed [31:0] productT;  // full 16x16 product
    typedef logic [7:0]  apbAddrT;         // byte address
    typedef logic [31:0] apbDataT;

    // master side of the apb port
    typedef struct packed {
        apbAddrT paddr;
        logic    psel;
        logic    penable;
        logic    pwrite;
        apbDataT pwdata;
    } apbReqT;

    // slave answer
    typedef struct packed {
        apbDataT prdata;
        logic    pready;   // tied high for no wait states
        logic    pslverr;
    } apbRspT;

    // operand pair for one multiplier unit
    typedef struct packed {
        operandT multiplicand;
        operandT multiplier;
    } mulJobT;

    typedef enum logic [1:0] {stIdle, stLoad, stRun, stDone} boothStateT;

    // accumulator mux select shared by control and datapath
    localparam logic [1:0] selPass = 2'b00;
    localparam logic [1:0] selAdd  = 2'b01;
    localparam logic [1:0] selSub  = 2'b10;

    // register offsets
    localparam apbAddrT regOpAB    = 8'h00;
    localparam apbAddrT regOpCD    = 8'h04;
    localparam apbAddrT regCtrl    = 8'h08;
    localparam apbAddrT regStatus  = 8'h0C;
    localparam apbAddrT regResLo   = 8'h10;
    localparam apbAddrT regResHi   = 8'h14;

endpackage

`default_nettype wire

// ==== design/boothDatapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module boothDatapath import dotMacPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    input  operandT    multiplicand,
    input  operandT    multiplier,
    input  logic       selectMultiplier,   // 0 load, 1 step
    input  logic [1:0] selectAccumulator,
    output logic [1:0] operation,
    output logic       count16,
    output productT    product
);

    // 17 bit acc so that subtracting -32768 cannot overflow
    logic signed [16:0] mReg;
    logic signed [16:0] accReg;
    logic signed [16:0] accNext;
    logic [15:0] qReg;
    logic        qExtra;       // the q(-1) bit
    logic [3:0]  stepCount;

    // add / subtract / pass
    always_comb begin
        case (selectAccumulator)
            selAdd:  accNext = accReg + mReg;
            selSub:  accNext = accReg - mReg;
            default: accNext = accReg;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mReg      <= '0;
            accReg    <= '0;
            qReg      <= '0;
            qExtra    <= 1'b0;
            stepCount <= '0;
        end else if (!enable) begin
            // idle clears everything back to zero
            mReg      <= '0;
            accReg    <= '0;
            qReg      <= '0;
            qExtra    <= 1'b0;
            stepCount <= '0;
        end else if (!selectMultiplier) begin
            mReg      <= {multiplicand[15], multiplicand};  // sign extend
            accReg    <= '0;
            qReg      <= multiplier;
            qExtra    <= 1'b0;
            stepCount <= '0;
        end else begin
            // arithmetic shift of the acc:q:extra chain
            {accReg, qReg, qExtra} <= {accNext[16], accNext, qReg};
            stepCount              <= stepCount + 4'd1;
        end
    end

    assign operation = {qReg[0], qExtra};   // booth bit pair
    // high while the 16th shift is taken so the chain is final one cycle later
    assign count16   = (stepCount == 4'd15);
    assign product   = {accReg[15:0], qReg};

    // controller only ever asks for add, sub or pass
    selLegal: assert property (@(posedge clk) disable iff (!reset)
        selectAccumulator != 2'b11);

endmodule

`default_nettype wire

// ==== design/boothControl.sv ====
`timescale 1ns/10ps
`default_nettype none

module boothControl import dotMacPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic [1:0] operation,
    input  logic       count16,
    output logic       enable,
    output logic       selectMultiplier,
    output logic [1:0] selectAccumulator,
    output logic       done
);

    boothStateT state, stateNext;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= stIdle;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            stIdle:  if (start) stateNext = stLoad;
            stLoad:  stateNext = stRun;          // operands captured here
            stRun:   if (count16) stateNext = stDone;
            stDone:  stateNext = stIdle;
            default: stateNext = stIdle;
        endcase
    end

    // datapath is only alive in load and run and clears again in done
    assign enable           = (state == stLoad) || (state == stRun);
    assign selectMultiplier = (state == stRun);
    assign done             = (state == stDone);

    // booth recoding of the current bit pair
    always_comb begin
        selectAccumulator = selPass;
        if (state == stRun) begin
            case (operation)
                2'b01:   selectAccumulator = selAdd;
                2'b10:   selectAccumulator = selSub;
                default: selectAccumulator = selPass;  // 00 and 11
            endcase
        end
    end

    // accepted start gives one done cycle 18 cycles later
    donePulse: assert property (@(posedge clk) disable iff (!reset)
        (state == stIdle && start) |-> ##18 (done ##1 !done));

endmodule

`default_nettype wire

// ==== design/boothMultiplier.sv ====
`timescale 1ns/10ps
`default_nettype none

module boothMultiplier import dotMacPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    start,
    input  mulJobT  job,
    output logic    done,
    output productT product
);

    logic       enable;
    logic       selectMultiplier;
    logic [1:0] selectAccumulator;
    logic [1:0] operation;
    logic       count16;
    logic       ctlDone;
    productT    dpProduct;
    productT    heldProduct;   // survives the datapath clear

    boothControl u_control (
        .clk               (clk),
        .reset             (reset),
        .start             (start),
        .operation         (operation),
        .count16           (count16),
        .enable            (enable),
        .selectMultiplier  (selectMultiplier),
        .selectAccumulator (selectAccumulator),
        .done              (ctlDone)
    );

    boothDatapath u_datapath (
        .clk               (clk),
        .reset             (reset),
        .enable            (enable),
        .multiplicand      (job.multiplicand),
        .multiplier        (job.multiplier),
        .selectMultiplier  (selectMultiplier),
        .selectAccumulator (selectAccumulator),
        .operation         (operation),
        .count16           (count16),
        .product           (dpProduct)
    );

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            heldProduct <= '0;
        end else if (ctlDone) begin
            heldProduct <= dpProduct;  // grab before idle clears it
        end
    end

    assign done    = ctlDone;
    // live value in the done cycle and the held copy afterwards
    assign product = ctlDone ? dpProduct : heldProduct;

endmodule

`default_nettype wire

// ==== design/dotCombiner.sv ====
`timescale 1ns/10ps
`default_nettype none

module dotCombiner import dotMacPkg::*; #(
    parameter int accWidth = 40
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                accumulate,
    input  logic                clearAcc,
    input  logic                doneAB,
    input  productT             productAB,
    input  logic                doneCD,
    input  productT             productCD,
    output logic                resultValid,
    output logic [accWidth-1:0] acc
);

    logic flagAB;        // product ab arrived earlier
    logic flagCD;
    logic accMode;       // mode of the running job
    logic arrivedAB;
    logic arrivedCD;
    logic bothArrived;
    logic signed [32:0]         pairSum;
    logic signed [accWidth-1:0] sumExt;

    assign arrivedAB   = flagAB | doneAB;
    assign arrivedCD   = flagCD | doneCD;
    assign bothArrived = arrivedAB & arrivedCD;

    assign pairSum = productAB + productCD;  // 33 bits cannot overflow
    assign sumExt  = pairSum;                // sign extends to acc width

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            flagAB      <= 1'b0;
            flagCD      <= 1'b0;
            accMode     <= 1'b0;
            resultValid <= 1'b0;
            acc         <= '0;
        end else begin
            resultValid <= bothArrived;
            if (start) begin
                accMode <= accumulate;
                flagAB  <= 1'b0;
                flagCD  <= 1'b0;
            end else if (bothArrived) begin
                flagAB  <= 1'b0;   // job consumed
                flagCD  <= 1'b0;
            end else begin
                flagAB  <= arrivedAB;
                flagCD  <= arrivedCD;
            end
            // clear wins over a finishing job
            if (clearAcc) begin
                acc <= '0;
            end else if (bothArrived) begin
                acc <= accMode ? acc + sumExt : sumExt;  // wraps at accWidth
            end
        end
    end

    // each unit finishes at most once per job
    singleDone: assert property (@(posedge clk) disable iff (!reset)
        !(doneAB && flagAB) && !(doneCD && flagCD));

endmodule

`default_nettype wire

// ==== design/apbDotRegs.sv ====
`timescale 1ns/10ps
`default_nettype none

module apbDotRegs import dotMacPkg::*; #(
    parameter int accWidth = 40
) (
    input  logic                clk,
    input  logic                reset,
    input  apbReqT              apbReq,
    output apbRspT              apbRsp,
    output mulJobT              jobAB,
    output mulJobT              jobCD,
    output logic                start,
    output logic                accumulate,
    output logic                clearAcc,
    input  logic                resultValid,
    input  logic [accWidth-1:0] acc
);

    apbDataT opAB;   // b:a
    apbDataT opCD;   // d:c
    apbDataT readData;
    logic    busy;
    logic    doneFlag;   // sticky until next start
    logic    access;
    logic    writeAccess;
    logic    ctrlWrite;
    logic    startReq;
    logic    startReject;
    logic    knownAddr;
    logic signed [63:0] accWide;

    // transfer completes in the access phase since pready is constant
    assign access      = apbReq.psel & apbReq.penable;
    assign writeAccess = access & apbReq.pwrite;
    assign ctrlWrite   = writeAccess && (apbReq.paddr == regCtrl);
    assign startReq    = ctrlWrite & apbReq.pwdata[0];
    assign startReject = startReq & busy;   // job in flight

    assign accWide = $signed(acc);   // sign extend for the hi word

    always_comb begin
        knownAddr = 1'b1;
        readData  = '0;
        case (apbReq.paddr)
            regOpAB:   readData = opAB;
            regOpCD:   readData = opCD;
            regCtrl:   readData = {30'd0, accumulate, 1'b0};
            regStatus: readData = {30'd0, doneFlag, busy};
            regResLo:  readData = accWide[31:0];
            regResHi:  readData = accWide[63:32];
            default:   knownAddr = 1'b0;
        endcase
    end

    assign apbRsp.prdata  = readData;
    assign apbRsp.pready  = 1'b1;
    assign apbRsp.pslverr = access & (!knownAddr | startReject);

    // a feeds the multiplicand and b the multiplier
    assign jobAB = '{multiplicand: opAB[15:0], multiplier: opAB[31:16]};
    assign jobCD = '{multiplicand: opCD[15:0], multiplier: opCD[31:16]};

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            opAB       <= '0;
            opCD       <= '0;
            busy       <= 1'b0;
            doneFlag   <= 1'b0;
            start      <= 1'b0;
            accumulate <= 1'b0;
            clearAcc   <= 1'b0;
        end else begin
            start    <= startReq & !busy;          // one cycle pulse
            clearAcc <= ctrlWrite & apbReq.pwdata[2];
            if (writeAccess && apbReq.paddr == regOpAB) opAB <= apbReq.pwdata;
            if (writeAccess && apbReq.paddr == regOpCD) opCD <= apbReq.pwdata;
            if (startReq && !busy) begin
                busy       <= 1'b1;
                doneFlag   <= 1'b0;
                accumulate <= apbReq.pwdata[1];  // mode travels with start
            end else if (resultValid) begin
                busy       <= 1'b0;
                doneFlag   <= 1'b1;
            end
        end
    end

    // access phase always follows a setup phase with psel held
    penableWithPsel: assert property (@(posedge clk) disable iff (!reset)
        apbReq.penable |-> apbReq.psel);

endmodule

`default_nettype wire

// ==== design/dotMacTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module dotMacTop import dotMacPkg::*; #(
    parameter int accWidth = 40
) (
    input  logic   clk,
    input  logic   reset,
    input  apbReqT apbReq,
    output apbRspT apbRsp
);

    mulJobT  jobAB, jobCD;
    logic    start, accumulate, clearAcc, resultValid;
    logic    doneAB, doneCD;
    productT productAB, productCD;
    logic [accWidth-1:0] acc;

    apbDotRegs #(.accWidth(accWidth)) u_regs (
        .clk (clk), .reset (reset),
        .apbReq      (apbReq),
        .apbRsp      (apbRsp),
        .jobAB       (jobAB),
        .jobCD       (jobCD),
        .start       (start),
        .accumulate  (accumulate),
        .clearAcc    (clearAcc),
        .resultValid (resultValid),
        .acc         (acc)
    );

    // a*b and c*d run in lockstep
    boothMultiplier u_mulAB (
        .clk (clk), .reset (reset), .start (start),
        .job (jobAB), .done (doneAB), .product (productAB)
    );

    boothMultiplier u_mulCD (
        .clk (clk), .reset (reset), .start (start),
        .job (jobCD), .done (doneCD), .product (productCD)
    );

    dotCombiner #(.accWidth(accWidth)) u_combiner (
        .clk (clk), .reset (reset),
        .start (start), .accumulate (accumulate), .clearAcc (clearAcc),
        .doneAB (doneAB), .productAB (productAB),
        .doneCD (doneCD), .productCD (productCD),
        .resultValid (resultValid),
        .acc         (acc)
    );

endmodule

`default_nettype wire

// ==== bench/tbDotMac.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbDotMac import dotMacPkg::*;;

    localparam int clkHalf   = 2;    // 4 ns period
    localparam int numCorner = 8;
    localparam int numRandom = 40;
    localparam int numAccum  = 12;
    localparam int numJobs   = numCorner + numRandom + numAccum + 1;  // +1 busy job
    localparam int watchdogCycles = numJobs * 40 + 200;

    logic   clk;
    logic   reset;
    apbReqT req;
    apbRspT rsp;

    integer seed;
    integer errors;
    integer checks;
    longint accModel;   // reference acc sign extended from 40 bits

    dotMacTop #(.accWidth(40)) u_dut (
        .clk    (clk),
        .reset  (reset),
        .apbReq (req),
        .apbRsp (rsp)
    );

    always #clkHalf clk = ~clk;

    // no wait states ever
    readyHigh: assert property (@(posedge clk) disable iff (!reset) rsp.pready)
        else begin
            errors = errors + 1;
            $display("mismatch pready: got %h expected %h", rsp.pready, 1'b1);
        end

    // error flag only inside an access phase
    errInAccess: assert property (@(posedge clk) disable iff (!reset)
        rsp.pslverr |-> (req.psel && req.penable))
        else begin
            errors = errors + 1;
            $display("pslverr raised outside an access phase");
        end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks = checks + 1;
        assert (got === exp)
            else begin
                errors = errors + 1;
                $display("mismatch %s: got %h expected %h", name, got, exp);
            end
    endtask

    // caller sits 1 ns after a rising edge and ends there again
    task automatic apbWrite(input apbAddrT addr, input apbDataT data, output logic err);
        req = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: 1'b1, pwdata: data};
        @(posedge clk);
        #1 req.penable = 1'b1;
        #1 err = rsp.pslverr;   // mid access phase where it is stable
        @(posedge clk);
        #1 req = '0;
    endtask

    task automatic apbRead(input apbAddrT addr, output apbDataT data, output logic err);
        req = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: 1'b0, pwdata: '0};
        @(posedge clk);
        #1 req.penable = 1'b1;
        #1 begin
            data = rsp.prdata;
            err  = rsp.pslverr;
        end
        @(posedge clk);
        #1 req = '0;
    endtask

    // keep the low 40 bits and sign extend to 64
    function automatic longint wrap40(input longint v);
        logic [39:0] t;
        t = v[39:0];
        return {{24{t[39]}}, t};
    endfunction

    // {a, b, c, d}
    function automatic logic [63:0] cornerJob(input int idx);
        case (idx)
            0:       return 64'h0000_0000_0000_0000;
            1:       return 64'h0001_0001_FFFF_FFFF;
            2:       return 64'hFFFF_0001_0001_FFFF;
            3:       return 64'h7FFF_7FFF_7FFF_7FFF;
            4:       return 64'h8000_8000_8000_8000;   // both -32768 squared
            5:       return 64'h8000_7FFF_7FFF_8000;
            6:       return 64'h8000_0001_FFFF_8000;
            default: return 64'h7FFF_FFFF_0000_8000;
        endcase
    endfunction

    task automatic startJob(input operandT a, input operandT b, input operandT c,
                            input operandT d, input logic mode);
        logic   err;
        longint dot;
        dot = longint'(a) * longint'(b) + longint'(c) * longint'(d);
        accModel = mode ? wrap40(accModel + dot) : wrap40(dot);
        apbWrite(regOpAB, {b, a}, err);
        checkValue("pslverr opAB", {31'd0, err}, 32'd0);
        apbWrite(regOpCD, {d, c}, err);
        checkValue("pslverr opCD", {31'd0, err}, 32'd0);
        apbWrite(regCtrl, {30'd0, mode, 1'b1}, err);
        checkValue("pslverr start", {31'd0, err}, 32'd0);
    endtask

    task automatic checkResult();
        apbDataT data;
        logic    err;
        apbRead(regResLo, data, err);
        checkValue("resLo", data, accModel[31:0]);
        apbRead(regResHi, data, err);
        checkValue("resHi", data, accModel[63:32]);
    endtask

    // busy first and then poll until done
    task automatic finishJob();
        apbDataT st;
        logic    err;
        int      polls;
        apbRead(regStatus, st, err);
        checkValue("status busy", st, 32'h1);
        polls = 0;
        while (!st[1] && polls < 100) begin
            apbRead(regStatus, st, err);
            polls = polls + 1;
        end
        assert (st[1])
            else begin
                errors = errors + 1;
                $display("job never reported done in the status register");
            end
        checkValue("status done", st, 32'h2);
        checkResult();
    endtask

    task automatic randomJob(input logic mode);
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = $random(seed);
        r2 = $random(seed);
        startJob(r1[15:0], r1[31:16], r2[15:0], r2[31:16], mode);
        finishJob();
    endtask

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [63:0] cj;
        apbDataT     data;
        logic        err;
        clk      = 1'b0;
        reset    = 1'b0;
        req      = '0;
        seed     = 32'h73a2;
        errors   = 0;
        checks   = 0;
        accModel = 0;
        repeat (10) @(posedge clk);
        #1 reset = 1'b1;
        @(posedge clk);
        #1;

        // reset state and bad offsets
        apbRead(regStatus, data, err);
        checkValue("status after reset", data, 32'h0);
        apbRead(8'h18, data, err);
        checkValue("pslverr bad read", {31'd0, err}, 32'd1);
        apbWrite(8'h20, 32'h1234_5678, err);
        checkValue("pslverr bad write", {31'd0, err}, 32'd1);

        for (int i = 0; i < numCorner; i++) begin
            cj = cornerJob(i);
            startJob(cj[63:48], cj[47:32], cj[31:16], cj[15:0], 1'b0);
            finishJob();
        end

        for (int i = 0; i < numRandom; i++) begin
            randomJob(1'b0);
        end

        // clear then accumulate from zero
        apbWrite(regCtrl, 32'h4, err);
        accModel = 0;
        checkResult();
        for (int i = 0; i < numAccum; i++) begin
            randomJob(1'b1);
        end

        // second start while the first is running
        cj = cornerJob(5);
        startJob(cj[63:48], cj[47:32], cj[31:16], cj[15:0], 1'b0);
        apbWrite(regCtrl, 32'h3, err);
        checkValue("pslverr start busy", {31'd0, err}, 32'd1);
        finishJob();

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== Bender.yml ====
package:
  name: dot_mac

sources:
  - design/dotMacPkg.sv
  - design/boothDatapath.sv
  - design/boothControl.sv
  - design/boothMultiplier.sv
  - design/dotCombiner.sv
  - design/apbDotRegs.sv
  - design/dotMacTop.sv
  - target: simulation
    files:
      - bench/tbDotMac.sv

// ==== tb.f ====
design/dotMacPkg.sv
design/boothDatapath.sv
design/boothControl.sv
design/boothMultiplier.sv
design/dotCombiner.sv
design/apbDotRegs.sv
design/dotMacTop.sv
bench/tbDotMac.sv
